//--- Makefile
# Verilator build and run for the cpu testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/cpuTop.sv
// cpu top level joining sequencer, decoder, executor and result stage behind plain ports
`timescale 1ns/1ps

module cpuTop #(
    parameter int fetchCycles  = phasePkg::defaultFetchCycles,
    parameter int decodeCycles = phasePkg::defaultDecodeCycles,
    parameter int execCycles   = phasePkg::defaultExecCycles
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [isaPkg::instrWidth-1:0] instr,       // combinational program memory
    output logic [isaPkg::dataWidth-1:0]  instrAddr,
    output logic [isaPkg::dataWidth-1:0]  outData,
    output logic                          outStrobe,
    output logic                          halted
);

    logic                         phaseFetch;
    logic                         phaseDecode;
    logic                         phaseExec;
    logic                         commit;
    logic [isaPkg::dataWidth-1:0] regA;
    logic [isaPkg::dataWidth-1:0] regB;
    logic                         zeroFlag;
    logic                         carryFlag;

    instrBus  iBus ();
    resultBus rBus ();

    phaser #(
        .fetchCycles  (fetchCycles),
        .decodeCycles (decodeCycles),
        .execCycles   (execCycles)
    ) seqUnit (
        .clk         (clk),
        .reset       (reset),
        .halted      (halted),
        .phaseFetch  (phaseFetch),
        .phaseDecode (phaseDecode),
        .phaseExec   (phaseExec),
        .commit      (commit)
    );

    decoder decodeUnit (
        .clk         (clk),
        .reset       (reset),
        .phaseFetch  (phaseFetch),
        .phaseDecode (phaseDecode),
        .instr       (instr),
        .bus         (iBus.source)
    );

    executor execUnit (
        .clk       (clk),
        .reset     (reset),
        .phaseExec (phaseExec),
        .regA      (regA),
        .regB      (regB),
        .zeroFlag  (zeroFlag),
        .carryFlag (carryFlag),
        .bus       (iBus.sink),
        .res       (rBus.source)
    );

    // pc doubles as the program memory address
    resultWriter resultUnit (
        .clk       (clk),
        .reset     (reset),
        .commit    (commit),
        .fields    (iBus.sink),
        .res       (rBus.sink),
        .regA      (regA),
        .regB      (regB),
        .zeroFlag  (zeroFlag),
        .carryFlag (carryFlag),
        .pc        (instrAddr),
        .outData   (outData),
        .outStrobe (outStrobe),
        .halted    (halted)
    );

endmodule

//--- hdl/decoder.sv
// instruction decoder, latches the program word in fetch and splits out the fields in decode
`timescale 1ns/1ps

module decoder (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          phaseFetch,
    input  logic                          phaseDecode,
    input  logic [isaPkg::instrWidth-1:0] instr,     // program memory answer
    instrBus.source                       bus
);

    localparam int opLsb = isaPkg::instrWidth - isaPkg::opcodeWidth;
    localparam int rdLsb = opLsb - isaPkg::regSelWidth;

    logic [isaPkg::instrWidth-1:0]  instrWord;      // held copy of the program word
    logic [isaPkg::opcodeWidth-1:0] opBits;
    isaPkg::opcode_t                opDecoded;

    // last fetch clock wins, instrAddr does not move during fetch
    always_ff @(posedge clk) begin
        if (phaseFetch) begin
            instrWord <= instr;
        end
    end

    assign opBits = instrWord[opLsb +: isaPkg::opcodeWidth];

    // codes past HALT are not defined
    always_comb begin
        if (opBits > isaPkg::HALT) begin
            opDecoded = isaPkg::NOP;
        end else begin
            opDecoded = isaPkg::opcode_t'(opBits);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.op <= isaPkg::NOP;
        end else if (phaseDecode) begin
            bus.op <= opDecoded;
        end
    end

    // operand fields, payload only
    always_ff @(posedge clk) begin
        if (phaseDecode) begin
            bus.rd  <= instrWord[rdLsb +: isaPkg::regSelWidth];
            bus.rs  <= instrWord[isaPkg::immWidth +: isaPkg::regSelWidth];
            bus.imm <= instrWord[isaPkg::immWidth-1:0];
        end
    end

endmodule

//--- hdl/executor.sv
// execute unit, ALU, zero/carry flags and branch decision feeding the commit request
`timescale 1ns/1ps

module executor (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         phaseExec,
    input  logic [isaPkg::dataWidth-1:0] regA,       // r[rd]
    input  logic [isaPkg::dataWidth-1:0] regB,       // r[rs]
    input  logic                         zeroFlag,
    input  logic                         carryFlag,
    instrBus.sink                        bus,
    resultBus.source                     res
);

    // seven strobes/flags, write select, data and target
    localparam int reqWidth = 7 + isaPkg::regSelWidth + 2 * isaPkg::dataWidth;

    logic [isaPkg::dataWidth:0]   sum;      // 9 bit for carry and borrow
    logic [isaPkg::dataWidth-1:0] data;
    logic                         writeEn;
    logic                         flagEn;
    logic                         carry;
    logic                         outEn;
    logic                         jumpEn;
    logic                         haltEn;
    logic [reqWidth-1:0]          liveReq;
    logic [reqWidth-1:0]          heldReq;
    logic                         execHeld;  // past the first execute clock

    always_comb begin
        sum     = '0;
        data    = regA;         // OUT sends rd
        writeEn = 1'b0;
        flagEn  = 1'b0;
        carry   = carryFlag;    // kept unless ADD/SUB or a logic op
        outEn   = 1'b0;
        jumpEn  = 1'b0;
        haltEn  = 1'b0;
        case (bus.op)
            isaPkg::LDI: begin
                data    = bus.imm;
                writeEn = 1'b1;
                flagEn  = 1'b1;
            end
            isaPkg::MOV: begin
                data    = regB;
                writeEn = 1'b1;
                flagEn  = 1'b1;
            end
            isaPkg::ADD, isaPkg::SUB: begin
                if (bus.op == isaPkg::ADD) begin
                    sum = {1'b0, regA} + {1'b0, regB};
                end else begin
                    sum = {1'b0, regA} - {1'b0, regB};   // msb set on borrow
                end
                data    = sum[isaPkg::dataWidth-1:0];
                carry   = sum[isaPkg::dataWidth];
                writeEn = 1'b1;
                flagEn  = 1'b1;
            end
            isaPkg::AND, isaPkg::OR, isaPkg::XOR: begin
                case (bus.op)
                    isaPkg::AND: data = regA & regB;
                    isaPkg::OR:  data = regA | regB;
                    default:     data = regA ^ regB;
                endcase
                carry   = 1'b0;
                writeEn = 1'b1;
                flagEn  = 1'b1;
            end
            isaPkg::OUT:  outEn  = 1'b1;
            isaPkg::JMP:  jumpEn = 1'b1;
            isaPkg::JZ:   jumpEn = zeroFlag;
            isaPkg::JC:   jumpEn = carryFlag;
            isaPkg::HALT: haltEn = 1'b1;
            default: ;                                  // NOP
        endcase
    end

    assign liveReq = {writeEn, flagEn, (data == '0), carry, outEn, jumpEn, haltEn,
                      bus.rd, data, bus.imm};

    always_ff @(posedge clk) begin
        if (reset) begin
            execHeld <= 1'b0;
        end else begin
            execHeld <= phaseExec;
        end
    end

    // snapshot on the first execute clock, breaks the regfile to regfile path
    always_ff @(posedge clk) begin
        if (phaseExec && !execHeld) begin
            heldReq <= liveReq;
        end
    end

    // single clock execute commits straight off the ALU, same value as the snapshot
    assign {res.writeEn, res.flagEn, res.zero, res.carry, res.outEn, res.jumpEn,
            res.haltEn, res.writeReg, res.writeData, res.jumpTarget} =
           execHeld ? heldReq : liveReq;

endmodule

//--- hdl/instrBus.sv
// decoded instruction fields passed from the decoder to the executor and the register read port
`timescale 1ns/1ps

interface instrBus;

    isaPkg::opcode_t                op;
    logic [isaPkg::regSelWidth-1:0] rd;    // destination, also first operand
    logic [isaPkg::regSelWidth-1:0] rs;    // second operand
    logic [isaPkg::immWidth-1:0]    imm;   // immediate or jump target

    // fields stay put through decode and execute
    modport source (
        output op,
        output rd,
        output rs,
        output imm
    );

    modport sink (
        input op,
        input rd,
        input rs,
        input imm
    );

endinterface

//--- hdl/isaPkg.sv
// instruction set definitions shared by the decoder, executor, result stage and cpu top level
package isaPkg;

    localparam int dataWidth   = 8;                 // registers, data and pc
    localparam int regSelWidth = 2;                 // r0..r3
    localparam int numRegs     = 1 << regSelWidth;
    localparam int instrWidth  = 16;
    localparam int opcodeWidth = 4;                 // bits 15..12
    localparam int immWidth    = 8;                 // bits 7..0, also the jump target

    // 13..15 are unused, decoder turns them into NOP
    typedef enum logic [opcodeWidth-1:0] {
        NOP  = 4'd0,
        LDI  = 4'd1,    // rd = imm
        MOV  = 4'd2,    // rd = rs
        ADD  = 4'd3,
        SUB  = 4'd4,    // carry holds the borrow
        AND  = 4'd5,
        OR   = 4'd6,
        XOR  = 4'd7,
        OUT  = 4'd8,    // output port = rd
        JMP  = 4'd9,
        JZ   = 4'd10,
        JC   = 4'd11,
        HALT = 4'd12
    } opcode_t;

endpackage

//--- hdl/phasePkg.sv
// sequencing definitions for the phase sequencer and the default phase lengths of the cpu top
package phasePkg;

    // step groups of one instruction, dead is always a single clock
    typedef enum logic [1:0] {
        DEAD,
        FETCH,
        DECODE,
        EXEC
    } phase_t;

    // clocks spent in each phase, all must be 1 or more
    localparam int defaultFetchCycles  = 1;
    localparam int defaultDecodeCycles = 2;
    localparam int defaultExecCycles   = 2;

endpackage

//--- hdl/phaser.sv
// phase sequencer stepping each instruction through dead, fetch, decode and execute plus commit
`timescale 1ns/1ps

module phaser #(
    parameter int fetchCycles  = phasePkg::defaultFetchCycles,
    parameter int decodeCycles = phasePkg::defaultDecodeCycles,
    parameter int execCycles   = phasePkg::defaultExecCycles
) (
    input  logic clk,
    input  logic reset,
    input  logic halted,        // parks the sequence in dead
    output logic phaseFetch,
    output logic phaseDecode,
    output logic phaseExec,
    output logic commit         // last execute clock
);

    localparam int maxFd     = (fetchCycles > decodeCycles) ? fetchCycles : decodeCycles;
    localparam int maxCycles = (maxFd > execCycles) ? maxFd : execCycles;
    localparam int stepWidth = $clog2(maxCycles + 1);  // at least one bit

    phasePkg::phase_t     phase;
    logic [stepWidth-1:0] step;       // clocks spent so far in this phase
    logic [stepWidth-1:0] phaseLen;
    logic                 lastStep;

    always_comb begin
        case (phase)
            phasePkg::FETCH:  phaseLen = stepWidth'(fetchCycles);
            phasePkg::DECODE: phaseLen = stepWidth'(decodeCycles);
            phasePkg::EXEC:   phaseLen = stepWidth'(execCycles);
            default:          phaseLen = stepWidth'(1);     // dead
        endcase
    end

    assign lastStep = (step == phaseLen - 1'b1);
    assign commit   = phaseExec && lastStep;

    // levels behave like set/reset latches, set entering a phase and cleared leaving it
    // dead clock after reset keeps the first fetch edge from being lost
    always_ff @(posedge clk) begin
        if (reset) begin
            phase       <= phasePkg::DEAD;
            step        <= '0;
            phaseFetch  <= 1'b0;
            phaseDecode <= 1'b0;
            phaseExec   <= 1'b0;
        end else if (lastStep) begin
            step <= '0;
            case (phase)
                phasePkg::DEAD: begin
                    if (!halted) begin
                        phase      <= phasePkg::FETCH;
                        phaseFetch <= 1'b1;
                    end
                end
                phasePkg::FETCH: begin
                    phase       <= phasePkg::DECODE;
                    phaseFetch  <= 1'b0;
                    phaseDecode <= 1'b1;
                end
                phasePkg::DECODE: begin
                    phase       <= phasePkg::EXEC;
                    phaseDecode <= 1'b0;
                    phaseExec   <= 1'b1;
                end
                default: begin                  // exec wraps to dead
                    phase     <= phasePkg::DEAD;
                    phaseExec <= 1'b0;
                end
            endcase
        end else begin
            step <= step + 1'b1;
        end
    end

endmodule

//--- hdl/resultBus.sv
// commit request from the executor to the result stage, sampled on the commit clock
`timescale 1ns/1ps

interface resultBus;

    logic                           writeEn;     // register file write
    logic [isaPkg::regSelWidth-1:0] writeReg;
    logic [isaPkg::dataWidth-1:0]   writeData;   // also the OUT value
    logic                           flagEn;      // load zero and carry
    logic                           zero;
    logic                           carry;
    logic                           outEn;
    logic                           jumpEn;      // taken jump
    logic [isaPkg::dataWidth-1:0]   jumpTarget;
    logic                           haltEn;

    modport source (
        output writeEn, writeReg, writeData,
        output flagEn, zero, carry,
        output outEn,
        output jumpEn, jumpTarget,
        output haltEn
    );

    modport sink (
        input writeEn, writeReg, writeData,
        input flagEn, zero, carry,
        input outEn,
        input jumpEn, jumpTarget,
        input haltEn
    );

endinterface

//--- hdl/resultWriter.sv
// result stage holding registers, flags, pc, output port and halt latch, all updated on commit
`timescale 1ns/1ps

module resultWriter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         commit,     // one clock per instruction
    instrBus.sink                        fields,     // read selects
    resultBus.sink                       res,
    output logic [isaPkg::dataWidth-1:0] regA,
    output logic [isaPkg::dataWidth-1:0] regB,
    output logic                         zeroFlag,
    output logic                         carryFlag,
    output logic [isaPkg::dataWidth-1:0] pc,
    output logic [isaPkg::dataWidth-1:0] outData,
    output logic                         outStrobe,
    output logic                         halted
);

    logic [isaPkg::dataWidth-1:0] regFile [isaPkg::numRegs];   // r0..r3

    // read ports follow the decoded fields
    assign regA = regFile[fields.rd];
    assign regB = regFile[fields.rs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < isaPkg::numRegs; i++) begin
                regFile[i] <= '0;
            end
            zeroFlag  <= 1'b0;
            carryFlag <= 1'b0;
            pc        <= '0;
            outStrobe <= 1'b0;
            halted    <= 1'b0;
        end else begin
            outStrobe <= commit && res.outEn;   // one clock after OUT commits
            if (commit) begin
                if (res.writeEn) begin
                    regFile[res.writeReg] <= res.writeData;
                end
                if (res.flagEn) begin
                    zeroFlag  <= res.zero;
                    carryFlag <= res.carry;
                end
                // HALT still steps past itself
                if (res.jumpEn) begin
                    pc <= res.jumpTarget;
                end else begin
                    pc <= pc + 1'b1;
                end
                if (res.haltEn) begin
                    halted <= 1'b1;             // only reset clears it
                end
            end
        end
    end

    // port value holds until the next OUT
    always_ff @(posedge clk) begin
        if (commit && res.outEn) begin
            outData <= res.writeData;
        end
    end

endmodule

//--- tb.f
hdl/isaPkg.sv
hdl/phasePkg.sv
hdl/instrBus.sv
hdl/resultBus.sv
hdl/phaser.sv
hdl/decoder.sv
hdl/executor.sv
hdl/resultWriter.sv
hdl/cpuTop.sv
+incdir+verif
verif/cpuTb.sv

//--- verif/cpuTests.svh
// directed test tasks and the cpu reference model that the testbench module includes
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

function automatic logic [15:0] encode(isaPkg::opcode_t op, int rd, int rs, int imm);
    return {op, 2'(rd), 2'(rs), 8'(imm)};   // op | rd | rs | imm
endfunction

task automatic emit(isaPkg::opcode_t op, int rd, int rs, int imm);
    progMem[emitAddr] = encode(op, rd, rs, imm);
    emitAddr++;
endtask

// unused words are HALT with their own address as immediate
task automatic clearProgram();
    for (int a = 0; a < 256; a++) begin
        progMem[a] = encode(isaPkg::HALT, 0, 0, a);
    end
    emitAddr = 0;
endtask

// steps the loaded program from address 0 to HALT and fills expOut and expHaltAddr
task automatic runModel(output int steps);
    logic [7:0]  r [4];
    logic [7:0]  pcM;
    logic [15:0] w;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [8:0]  wide;     // bit 8 is carry or borrow
    logic        zf;
    logic        cf;
    logic        stop;
    r     = '{default: '0};
    pcM   = '0;
    zf    = 1'b0;
    cf    = 1'b0;
    stop  = 1'b0;
    steps = 0;
    expOut.delete();
    while (!stop && steps < 2000) begin
        w     = progMem[pcM];
        a     = r[w[11:10]];
        b     = r[w[9:8]];
        wide  = '0;
        pcM   = pcM + 8'd1;
        steps = steps + 1;
        case (w[15:12])
            isaPkg::LDI:  wide = {1'b0, w[7:0]};
            isaPkg::MOV:  wide = {1'b0, b};
            isaPkg::ADD:  wide = {1'b0, a} + {1'b0, b};
            isaPkg::SUB:  wide = {1'b0, a} - {1'b0, b};  // wraps to bit 8 on borrow
            isaPkg::AND:  wide = {1'b0, a & b};
            isaPkg::OR:   wide = {1'b0, a | b};
            isaPkg::XOR:  wide = {1'b0, a ^ b};
            isaPkg::OUT:  expOut.push_back(a);
            isaPkg::JMP:  pcM = w[7:0];
            isaPkg::JZ:   pcM = zf ? w[7:0] : pcM;
            isaPkg::JC:   pcM = cf ? w[7:0] : pcM;
            isaPkg::HALT: stop = 1'b1;
            default: ;                                   // NOP and unused codes
        endcase
        if (w[15:12] inside {[isaPkg::LDI:isaPkg::XOR]}) begin
            r[w[11:10]] = wide[7:0];
            zf = (wide[7:0] == 8'h00);
            if (w[15:12] >= isaPkg::ADD) begin
                cf = wide[8];           // logic ops land here with a clear bit 8
            end
        end
    end
    if (!stop) begin
        $display("reference model ran 2000 steps without reaching HALT");
        errors++;
    end
    expHaltAddr = pcM;
endtask

task automatic applyReset();
    reset = 1'b1;
    repeat (resetCycles) @(negedge clk);
    gotOut.delete();                    // nothing strobes while reset is high
    reset = 1'b0;
endtask

task automatic waitOuts(int n);
    while (gotOut.size() < n) @(negedge clk);
endtask

// checks the order of OUT values only and no cycle positions
task automatic compareOut(string name);
    if (gotOut.size() != expOut.size()) begin
        valueError({name, " out count"}, gotOut.size(), expOut.size());
    end
    for (int i = 0; i < gotOut.size() && i < expOut.size(); i++) begin
        if (gotOut[i] !== expOut[i]) begin
            valueError({name, " out value"}, gotOut[i], expOut[i]);
        end
    end
endtask

task automatic runProgram(string name);
    int steps;
    runModel(steps);
    cycleLimit += steps * instrCycles + resetCycles + 10;
    applyReset();
    while (halted !== 1'b1) @(negedge clk);
    compareOut(name);
    if (instrAddr !== expHaltAddr) begin
        valueError({name, " halt address"}, instrAddr, expHaltAddr);
    end
    testsRun++;
endtask

task automatic checkLoadOut();
    logic [7:0] v [4];
    clearProgram();
    for (int i = 0; i < 4; i++) begin
        v[i] = 8'($urandom);
        emit(isaPkg::LDI, i, 0, v[i]);
    end
    for (int i = 0; i < 4; i++) begin
        emit(isaPkg::OUT, i, 0, 0);
    end
    emit(isaPkg::HALT, 0, 0, 0);
    runProgram("ldi/out");
    for (int i = 0; i < 4 && i < gotOut.size(); i++) begin
        if (gotOut[i] !== v[i]) valueError("loaded value", gotOut[i], v[i]);
    end
endtask

task automatic aluOps();
    isaPkg::opcode_t ops [5];
    ops = '{isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::OR, isaPkg::XOR};
    for (int round = 0; round < 3; round++) begin
        clearProgram();
        emit(isaPkg::LDI, 0, 0, $urandom);
        emit(isaPkg::LDI, 1, 0, $urandom);
        foreach (ops[j]) begin
            emit(isaPkg::MOV, 2, 0, 0);     // fresh copy of r0 as left operand
            emit(ops[j], 2, 1, 0);
            emit(isaPkg::OUT, 2, 0, 0);
        end
        emit(isaPkg::HALT, 0, 0, 0);
        runProgram("alu");
    end
endtask

// taken jump skips the miss marker and the hit marker always prints
task automatic branchTry(isaPkg::opcode_t op, int marker);
    emit(op, 0, 0, emitAddr + 3);
    emit(isaPkg::LDI, 3, 0, marker);
    emit(isaPkg::OUT, 3, 0, 0);
    emit(isaPkg::LDI, 3, 0, marker + 1);
    emit(isaPkg::OUT, 3, 0, 0);
endtask

task automatic flagCase(int a, int b, isaPkg::opcode_t op, int marker);
    emit(isaPkg::LDI, 0, 0, a);
    emit(isaPkg::LDI, 1, 0, b);
    emit(op, 0, 1, 0);
    branchTry(isaPkg::JZ, marker);      // JZ first since the marker LDIs clear zero
    branchTry(isaPkg::JC, marker + 4);  // carry survives LDI
endtask

task automatic branchFlags();
    clearProgram();
    flagCase(7, 7, isaPkg::SUB, 8'h10);         // zero and no borrow
    flagCase(3, 9, isaPkg::SUB, 8'h20);         // borrow only
    flagCase(8'hf0, 8'h10, isaPkg::ADD, 8'h30); // zero and carry
    flagCase(8'h5a, 8'h5a, isaPkg::XOR, 8'h40); // zero with carry cleared
    emit(isaPkg::HALT, 0, 0, 0);
    runProgram("branch");
endtask

task automatic countdownLoop();
    int n;
    n = $urandom_range(8, 3);
    clearProgram();
    emit(isaPkg::LDI, 0, 0, n);
    emit(isaPkg::LDI, 1, 0, 1);
    emit(isaPkg::OUT, 0, 0, 0);     // loop top at 2
    emit(isaPkg::SUB, 0, 1, 0);
    emit(isaPkg::JZ, 0, 0, 6);
    emit(isaPkg::JMP, 0, 0, 2);
    emit(isaPkg::OUT, 0, 0, 0);     // final zero
    emit(isaPkg::HALT, 0, 0, 0);
    runProgram("loop");
    for (int i = 0; i < gotOut.size(); i++) begin
        if (gotOut[i] !== 8'(n - i)) valueError("countdown", gotOut[i], n - i);
    end
endtask

task automatic haltHold();
    int seen;
    clearProgram();
    emit(isaPkg::LDI, 0, 0, 8'h5a);
    emit(isaPkg::OUT, 0, 0, 0);
    emit(isaPkg::HALT, 0, 0, 0);
    emit(isaPkg::OUT, 0, 0, 0);     // never reached
    runProgram("halt");
    cycleLimit += 60;
    seen = gotOut.size();
    repeat (50) @(negedge clk);
    if (halted !== 1'b1) valueError("halted level", halted, 1);
    if (gotOut.size() != seen) valueError("strobes after halt", gotOut.size(), seen);
    if (instrAddr !== 8'd3) valueError("address after halt", instrAddr, 3);
endtask

task automatic resetRestart();
    logic [7:0] v [4];
    clearProgram();
    for (int i = 0; i < 4; i++) begin
        emit(isaPkg::OUT, i, 0, 0);     // zeros straight after reset
    end
    for (int i = 0; i < 4; i++) begin
        v[i] = 8'($urandom) | 8'h01;    // nonzero so stale values show
        emit(isaPkg::LDI, i, 0, v[i]);
    end
    emit(isaPkg::JMP, 0, 0, 0);
    cycleLimit += 30 * instrCycles + 2 * resetCycles + 10;
    reset = 1'b1;                       // halted is still up from the halt test
    @(negedge clk);
    if (halted !== 1'b0) valueError("halted under reset", halted, 0);
    applyReset();
    waitOuts(5);                        // v0 from the second pass
    @(negedge clk);
    while (outStrobe !== 1'b1) @(negedge clk);  // strobe of OUT r1
    repeat (instrCycles - 1) @(negedge clk);    // commit clock of OUT r2
    reset = 1'b1;
    @(negedge clk);
    if (outStrobe !== 1'b0) valueError("strobe after mid-run reset", outStrobe, 0);
    if (instrAddr !== 8'd0) valueError("address after mid-run reset", instrAddr, 0);
    applyReset();
    waitOuts(8);
    for (int i = 0; i < 4; i++) begin
        if (gotOut[i] !== 8'h00) valueError("register after reset", gotOut[i], 0);
        if (gotOut[i + 4] !== v[i]) valueError("reloaded value", gotOut[i + 4], v[i]);
    end
    testsRun++;
endtask

`endif

//--- verif/cpuTb.sv
// testbench for the cpu top that models program memory and runs the directed tests
`timescale 1ns/1ps

module cpuTb;

    localparam int seed        = 63552;
    localparam int resetCycles = 5;
    localparam int baseMargin  = 200;   // cycles on top of the instruction budget
    localparam int instrCycles = 6;     // dead + fetch + 2 decode + 2 execute

    logic                          clk;
    logic                          reset;
    logic [isaPkg::instrWidth-1:0] instr;
    logic [isaPkg::dataWidth-1:0]  instrAddr;
    logic [isaPkg::dataWidth-1:0]  outData;
    logic                          outStrobe;
    logic                          halted;

    logic [isaPkg::instrWidth-1:0] progMem [256];  // one word per address
    logic [7:0] gotOut [$];                        // values seen on the output port
    logic [7:0] expOut [$];                        // values from the reference model
    logic [7:0] expHaltAddr;
    int         emitAddr;                          // next free program word
    int         errors     = 0;
    int         testsRun   = 0;
    int         cycleCount = 0;
    int         cycleLimit = baseMargin;           // grows as each test adds its budget

    cpuTop DUT (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .instrAddr (instrAddr),
        .outData   (outData),
        .outStrobe (outStrobe),
        .halted    (halted)
    );

    assign instr = progMem[instrAddr];  // combinational program memory

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // strobe is one clock wide so exactly one falling edge sees each OUT
    always @(negedge clk) begin
        if (!reset && outStrobe === 1'b1) begin
            gotOut.push_back(outData);
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycleCount);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic valueError(string what, int got, int exp);
        $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        errors++;
    endtask

    `include "cpuTests.svh"

    initial begin
        reset = 1'b1;
        void'($urandom(seed));          // the one seed of the run
        clearProgram();
        @(negedge clk);
        checkLoadOut();
        aluOps();
        branchFlags();
        countdownLoop();
        haltHold();
        resetRestart();                 // runs last and leaves the loop running
        $display("tests run: %0d  errors: %0d", testsRun, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
